/* logic/video_timing_pkg.sv */
// dot timing types shared by the timing generator and the pixel sequencer
// slot, line and blink widths bound the parameter ranges set at the top level
// raster_row is the line number modulo 8, so cells are always 8 lines tall
package video_timing_pkg;

    // character slot index within a line, up to 127 slots
    typedef logic [6:0] slot_num_t;
    // raster line index within a frame, up to 511 lines
    typedef logic [8:0] line_num_t;
    // pixel position within a slot
    typedef logic [2:0] pix_idx_t;
    // row inside a character cell
    typedef logic [2:0] raster_row_t;
    // frame counter for blink
    typedef logic [5:0] blink_ctr_t;

    // blink_ctr bit that gates blinking text, toggles every 16 frames
    localparam int blink_bit = 4;

    typedef struct packed {
        logic        pix_strobe;
        logic        slot_start;
        pix_idx_t    pix_idx;
        slot_num_t   slot_num;
        line_num_t   line_num;
        raster_row_t raster_row;
        blink_ctr_t  blink_ctr;
        logic        visible_h;
        logic        visible_v;
    } video_timing_t;

endpackage

/* logic/hires_mode_pkg.sv */
// display mode, register and pixel types for the hires path
// mode values 5 to 7 are illegal and produce background colour
// only the low 2 bits of the colour base are used by the 4-colour mode
package hires_mode_pkg;

    // 4-bit colour index, no palette lookup in this path
    typedef logic [3:0] color_t;

    typedef enum logic [2:0] {
        mode_text        = 3'd0,
        mode_cell_bitmap = 3'd1,
        mode_packed16    = 3'd2,
        mode_packed4     = 3'd3,
        mode_wide16      = 3'd4
    } hires_mode_e;

    // text attribute byte layout
    localparam int attr_color_msb     = 3;
    localparam int attr_blink_bit     = 4;
    localparam int attr_underline_bit = 5;
    localparam int attr_reverse_bit   = 6;

    typedef struct packed {
        hires_mode_e mode;
        logic [2:0]  xscroll;
        color_t      bg_color;
        color_t      border_color;
        logic [1:0]  color_base;
    } hires_regs_t;

    // one fetched byte pair, color_byte doubles as the high data byte
    // in the packed bitmap modes
    typedef struct packed {
        logic [7:0] pixel_byte;
        logic [7:0] color_byte;
        logic       cursor;
    } fetch_pair_t;

    typedef struct packed {
        color_t color;
        logic   is_background;
    } hires_pixel_t;

endpackage

/* logic/dot_timing_gen.sv */
// pixel strobe on every second clk_dot4x, 8 strobes per character slot
// first strobe comes 1 clock after rst is released, at line 0 slot 0 pixel 0
// SLOTS_PER_LINE and LINES_PER_FRAME must fit slot_num_t and line_num_t
`timescale 1ns/1ps

module dot_timing_gen #(
    parameter int SLOTS_PER_LINE  = 48,
    parameter int VIS_FIRST       = 4,
    parameter int VIS_LAST        = 43,
    parameter int LINES_PER_FRAME = 20,
    parameter int VIS_LINES       = 16
) (
    input  logic                           clk_dot4x,
    input  logic                           rst,
    output video_timing_pkg::video_timing_t timing
);
    import video_timing_pkg::*;

    // strobe phase, high on the strobe clock
    logic       phase;
    pix_idx_t   pix_idx;
    slot_num_t  slot_num;
    line_num_t  line_num;
    blink_ctr_t blink_ctr;
    logic       visible_h;
    logic       visible_v;
    logic       slot_wrap;
    logic       line_wrap;
    logic       frame_wrap;
    slot_num_t  slot_next;
    line_num_t  line_next;

    // wrap chain, each stage only advances when the one below wraps
    assign slot_wrap  = phase && (pix_idx == pix_idx_t'(7));
    assign line_wrap  = slot_wrap && (slot_num == slot_num_t'(SLOTS_PER_LINE - 1));
    assign frame_wrap = line_wrap && (line_num == line_num_t'(LINES_PER_FRAME - 1));
    assign slot_next  = line_wrap ? '0 : slot_num + 1'b1;
    assign line_next  = frame_wrap ? '0 : line_num + 1'b1;

    always_ff @(posedge clk_dot4x) begin
        if (!rst) begin
            phase     <= 1'b0;
            pix_idx   <= '0;
            slot_num  <= '0;
            line_num  <= '0;
            blink_ctr <= '0;
            // visible flags as decoded for slot 0 of line 0
            visible_h <= (VIS_FIRST == 0);
            visible_v <= (VIS_LINES > 0);
        end else begin
            phase <= ~phase;
            if (phase) begin
                pix_idx <= pix_idx + 1'b1;
            end
            if (slot_wrap) begin
                slot_num  <= slot_next;
                // decode the flag for the slot about to start
                visible_h <= (slot_next >= slot_num_t'(VIS_FIRST)) &&
                             (slot_next <= slot_num_t'(VIS_LAST));
            end
            if (line_wrap) begin
                line_num  <= line_next;
                visible_v <= (line_next < line_num_t'(VIS_LINES));
            end
            if (frame_wrap) begin
                blink_ctr <= blink_ctr + 1'b1;
            end
        end
    end

    assign timing = '{
        pix_strobe: phase,
        slot_start: phase && (pix_idx == '0),
        pix_idx:    pix_idx,
        slot_num:   slot_num,
        line_num:   line_num,
        raster_row: raster_row_t'(line_num),
        blink_ctr:  blink_ctr,
        visible_h:  visible_h,
        visible_v:  visible_v
    };

    // sequencer shifts once per strobe and relies on the idle clock between
    a_strobe_gap: assert property (@(posedge clk_dot4x) disable iff (!rst)
        timing.pix_strobe |=> !timing.pix_strobe);

endmodule

/* logic/hires_fetch_queue.sv */
// one-deep queue between the fetch side and the pixel sequencer
// a pair strobed in slot s is presented from the slot_start of slot s+1
// a slot without fetch_strobe presents an all-zero pair in the next slot
`timescale 1ns/1ps

module hires_fetch_queue (
    input  logic                       clk_dot4x,
    input  logic                       rst,
    input  logic                       slot_start,
    input  logic                       fetch_strobe,
    input  hires_mode_pkg::fetch_pair_t fetch_pair,
    output hires_mode_pkg::fetch_pair_t display_pair
);
    import hires_mode_pkg::*;

    // pair collected during the running slot
    fetch_pair_t pending;
    // pair on display for the running slot
    fetch_pair_t current;
    // a strobe already landed in this slot
    logic        seen;

    always_ff @(posedge clk_dot4x) begin
        if (!rst) begin
            pending <= '0;
            current <= '0;
            seen    <= 1'b0;
        end else if (slot_start) begin
            current <= pending;
            // a strobe on the slot_start clock belongs to the new slot
            pending <= fetch_strobe ? fetch_pair : fetch_pair_t'('0);
            seen    <= fetch_strobe;
        end else if (fetch_strobe) begin
            pending <= fetch_pair;
            seen    <= 1'b1;
        end
    end

    // bypass on slot_start so a load at pix_idx 0 already sees the new pair
    assign display_pair = slot_start ? pending : current;

    // the fetch side may deliver only one pair per slot
    a_one_fetch_per_slot: assert property (@(posedge clk_dot4x) disable iff (!rst)
        (fetch_strobe && !slot_start) |-> !seen);

endmodule

/* logic/hires_pixel_sequencer.sv */
// loads a byte pair at the strobe where pix_idx equals xscroll, then shifts
// once per strobe at the rate of the selected mode
// pixel is registered 1 clock after each pix_strobe, border outside visible area
// regs must stay stable within a slot, mode changes take effect mid-slot
`timescale 1ns/1ps

module hires_pixel_sequencer (
    input  logic                           clk_dot4x,
    input  logic                           rst,
    input  video_timing_pkg::video_timing_t timing,
    input  hires_mode_pkg::hires_regs_t     regs,
    input  hires_mode_pkg::fetch_pair_t     display_pair,
    output hires_mode_pkg::hires_pixel_t    pixel,
    output logic                           pixel_valid,
    output logic                           line_start
);
    import video_timing_pkg::*;
    import hires_mode_pkg::*;

    logic         in_display;
    logic         load;
    logic         byte_mode;
    fetch_pair_t  load_pair;
    // 1 bit per pixel data for text and cell bitmap
    logic [7:0]   shift8_q;
    logic [7:0]   shift8_src;
    logic [7:0]   shift8_next;
    // attribute latch, not shifted
    logic [7:0]   attr_q;
    logic [7:0]   attr_src;
    logic         cursor_q;
    logic         cursor_src;
    // packed data for the 16-bit modes
    logic [15:0]  shift16_q;
    logic [15:0]  shift16_src;
    logic [15:0]  shift16_next;
    // strobes since load, paces the slower packed modes
    logic [1:0]   phase_q;
    logic [1:0]   phase_src;
    logic         pix_bit;
    color_t       nibble;
    color_t       quad_color;
    logic         fg;
    hires_pixel_t pix_next;

    assign in_display = timing.visible_h && timing.visible_v;
    assign load       = timing.pix_strobe && (timing.pix_idx == pix_idx_t'(regs.xscroll));
    assign byte_mode  = (regs.mode == mode_text) || (regs.mode == mode_cell_bitmap);
    // outside the display the shifters are loaded with zeros
    assign load_pair  = in_display ? display_pair : fetch_pair_t'('0);

    // source for this strobe: freshly loaded data or the running shifters
    always_comb begin
        shift8_src  = shift8_q;
        attr_src    = attr_q;
        cursor_src  = cursor_q;
        shift16_src = shift16_q;
        phase_src   = phase_q;
        if (load) begin
            phase_src = '0;
            if (byte_mode) begin
                shift8_src = load_pair.pixel_byte;
                attr_src   = load_pair.color_byte;
                cursor_src = load_pair.cursor;
            end else if (regs.mode == mode_wide16) begin
                // only one data byte, placed high
                shift16_src = {load_pair.pixel_byte, 8'h00};
            end else begin
                shift16_src = {load_pair.color_byte, load_pair.pixel_byte};
            end
        end
    end

    // shift rate per mode
    always_comb begin
        shift8_next = {shift8_src[6:0], 1'b0};
        case (regs.mode)
            mode_packed16: begin
                // 4 bits every 2nd strobe
                shift16_next = phase_src[0] ? {shift16_src[11:0], 4'h0} : shift16_src;
            end
            mode_packed4: begin
                shift16_next = {shift16_src[13:0], 2'b00};
            end
            mode_wide16: begin
                // 4 bits every 4th strobe, each nibble is 4 pixels wide
                shift16_next = (phase_src == 2'd3) ? {shift16_src[11:0], 4'h0} : shift16_src;
            end
            default: begin
                shift16_next = shift16_src;
            end
        endcase
    end

    // colour resolve
    always_comb begin
        pix_bit    = shift8_src[7];
        nibble     = shift16_src[15:12];
        quad_color = {regs.color_base, shift16_src[15:14]};
        fg = pix_bit ^ (attr_src[attr_reverse_bit] | cursor_src);
        // underline fills the last cell row
        if (attr_src[attr_underline_bit] && (timing.raster_row == raster_row_t'(7))) begin
            fg = 1'b1;
        end
        // blink off phase hides everything, underline included
        if (attr_src[attr_blink_bit] && !timing.blink_ctr[blink_bit]) begin
            fg = 1'b0;
        end
        pix_next.color         = regs.bg_color;
        pix_next.is_background = 1'b1;
        if (!in_display) begin
            pix_next.color         = regs.border_color;
            pix_next.is_background = 1'b0;
        end else begin
            case (regs.mode)
                mode_text: begin
                    pix_next.color         = fg ? attr_src[attr_color_msb:0] : regs.bg_color;
                    // follows the raw bit, not the attributes
                    pix_next.is_background = !pix_bit;
                end
                mode_cell_bitmap: begin
                    pix_next.color         = pix_bit ? attr_src[attr_color_msb:0] : regs.bg_color;
                    pix_next.is_background = !pix_bit;
                end
                mode_packed16, mode_wide16: begin
                    pix_next.color         = nibble;
                    pix_next.is_background = (nibble == regs.bg_color);
                end
                mode_packed4: begin
                    pix_next.color         = quad_color;
                    pix_next.is_background = (quad_color == regs.bg_color);
                end
                default: begin
                    pix_next.color         = regs.bg_color;
                    pix_next.is_background = 1'b1;
                end
            endcase
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (!rst) begin
            shift8_q    <= '0;
            attr_q      <= '0;
            cursor_q    <= 1'b0;
            shift16_q   <= '0;
            phase_q     <= '0;
            pixel       <= '0;
            pixel_valid <= 1'b0;
            line_start  <= 1'b0;
        end else begin
            if (timing.pix_strobe) begin
                shift8_q  <= shift8_next;
                attr_q    <= attr_src;
                cursor_q  <= cursor_src;
                shift16_q <= shift16_next;
                phase_q   <= phase_src + 1'b1;
                pixel     <= pix_next;
            end
            pixel_valid <= timing.pix_strobe;
            // frame reference, marks pixel 0 of slot 0 on line 0 only
            line_start  <= timing.slot_start && (timing.slot_num == '0) &&
                           (timing.line_num == '0);
        end
    end

    a_legal_mode: assert property (@(posedge clk_dot4x) disable iff (!rst)
        regs.mode inside {mode_text, mode_cell_bitmap, mode_packed16, mode_packed4,
                          mode_wide16});

endmodule

/* logic/hires_video_top.sv */
// hires display path: dot timing, fetch queue and pixel sequencer
// registers are plain inputs and must be held stable while displaying
// fetch_pair is taken with fetch_strobe, at most one strobe per slot
`timescale 1ns/1ps

module hires_video_top #(
    parameter int SLOTS_PER_LINE  = 48,
    parameter int VIS_FIRST       = 4,
    parameter int VIS_LAST        = 43,
    parameter int LINES_PER_FRAME = 20,
    parameter int VIS_LINES       = 16
) (
    input  logic                        clk_dot4x,
    input  logic                        rst,
    input  hires_mode_pkg::hires_regs_t  regs,
    input  logic                        fetch_strobe,
    input  hires_mode_pkg::fetch_pair_t  fetch_pair,
    output hires_mode_pkg::hires_pixel_t pixel,
    output logic                        pixel_valid,
    output logic                        line_start
);
    import video_timing_pkg::*;
    import hires_mode_pkg::*;

    video_timing_t timing;
    // pair for the running slot
    fetch_pair_t   display_pair;

    dot_timing_gen #(
        .SLOTS_PER_LINE  (SLOTS_PER_LINE),
        .VIS_FIRST       (VIS_FIRST),
        .VIS_LAST        (VIS_LAST),
        .LINES_PER_FRAME (LINES_PER_FRAME),
        .VIS_LINES       (VIS_LINES)
    ) u_timing (
        .clk_dot4x (clk_dot4x),
        .rst       (rst),
        .timing    (timing)
    );

    hires_fetch_queue u_queue (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .slot_start   (timing.slot_start),
        .fetch_strobe (fetch_strobe),
        .fetch_pair   (fetch_pair),
        .display_pair (display_pair)
    );

    hires_pixel_sequencer u_seq (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .timing       (timing),
        .regs         (regs),
        .display_pair (display_pair),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .line_start   (line_start)
    );

endmodule

/* verification/dot_clock_gen.sv */
// free-running 100 ns clock for the testbench
// rst is active low, held for 4 rising edges and released 10 ns after the 4th
`timescale 1ns/1ps

module dot_clock_gen (
    output logic clk_dot4x,
    output logic rst
);

    initial begin
        clk_dot4x = 1'b0;
        forever begin
            #50 clk_dot4x = ~clk_dot4x;
        end
    end

    initial begin
        rst = 1'b0;
        repeat (4) @(posedge clk_dot4x);
        // released like any other input, just after the edge
        #10 rst = 1'b1;
    end

endmodule

/* verification/hires_video_tb.sv */
// directed tests for the hires display path, reduced to 16 slots by 12 lines
// every pixel after the first line_start is checked against a reference model
// regs only change at frame start, where all slots are border
// blink coverage needs 17 frames, about 5 ms of simulated time
`timescale 1ns/1ps

module hires_video_tb;
    import video_timing_pkg::*;
    import hires_mode_pkg::*;

    localparam int SLOTS        = 16;
    localparam int VIS_FIRST    = 2;
    localparam int VIS_LAST     = 11;
    localparam int LINES        = 12;
    localparam int VIS_LINES    = 10;
    localparam int FRAME_PIXELS = SLOTS * LINES * 8;

    logic         clk_dot4x;
    logic         rst;
    hires_regs_t  regs;
    logic         fetch_strobe;
    fetch_pair_t  fetch_pair;
    hires_pixel_t pixel;
    logic         pixel_valid;
    logic         line_start;

    integer       seed = 32'h5e206d52;
    // rst as sampled on the last rising edge
    logic         rst_seen;
    // position of the next pixel to check
    int           pos_pix;
    int           pos_slot;
    int           pos_line;
    int           frame_cnt;
    // pair loaded for this slot, for the previous one, and queued for the next
    fetch_pair_t  cur_pair;
    fetch_pair_t  prev_pair;
    fetch_pair_t  sent_pair;
    // 0 random pairs, 1 directed text attributes
    int           pair_kind;
    bit           skip_odd_fetch;

    dot_clock_gen u_clk (
        .clk_dot4x (clk_dot4x),
        .rst       (rst)
    );

    hires_video_top #(
        .SLOTS_PER_LINE  (SLOTS),
        .VIS_FIRST       (VIS_FIRST),
        .VIS_LAST        (VIS_LAST),
        .LINES_PER_FRAME (LINES),
        .VIS_LINES       (VIS_LINES)
    ) UUT (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .regs         (regs),
        .fetch_strobe (fetch_strobe),
        .fetch_pair   (fetch_pair),
        .pixel        (pixel),
        .pixel_valid  (pixel_valid),
        .line_start   (line_start)
    );

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_color(input string name, input color_t got, input color_t want);
        if (got !== want) begin
            abort_run($sformatf("ERR %0t %s got %h expected %h", $time, name, got, want));
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("ERR %0t %s got %b expected %b", $time, name, got, want));
        end
    endtask

    // outputs settle at the edge, inputs change 10 ns later
    task automatic next_cycle();
        @(posedge clk_dot4x);
        rst_seen = rst;
        #10;
        fetch_strobe = 1'b0;
    endtask

    task automatic wait_pixel();
        int n;
        for (n = 0; n < 4; n++) begin
            next_cycle();
            if (pixel_valid === 1'b1) begin
                break;
            end
        end
        if (pixel_valid !== 1'b1) begin
            abort_run("timeout, pixel_valid did not come within 4 clocks");
        end
    endtask

    task automatic set_regs(input hires_mode_e mode, input logic [2:0] xscroll,
                            input color_t bg, input color_t border, input logic [1:0] base);
        regs.mode         = mode;
        regs.xscroll      = xscroll;
        regs.bg_color     = bg;
        regs.border_color = border;
        regs.color_base   = base;
    endtask

    // text pairs cycle plain, reverse, cursor, underline and blink over the slots
    task automatic send_fetch(input int slot);
        fetch_pair_t p;
        p.pixel_byte = 8'($random(seed));
        p.color_byte = 8'($random(seed));
        p.cursor     = 1'($random(seed));
        if (pair_kind == 1) begin
            p.cursor = 1'b0;
            case (slot % 5)
                0: p.color_byte = 8'h07;
                1: p.color_byte = 8'h4c;
                2: begin
                    p.color_byte = 8'h03;
                    p.cursor     = 1'b1;
                end
                3: p.color_byte = 8'h29;
                default: p.color_byte = 8'h1e;
            endcase
        end
        fetch_pair   = p;
        fetch_strobe = 1'b1;
        sent_pair    = p;
    endtask

    // expected pixel at position pix of a slot, k counts strobes since the load
    function automatic hires_pixel_t expect_pixel(input hires_regs_t r, input fetch_pair_t cur,
            input fetch_pair_t prev, input int pix, input bit visible, input int row,
            input bit blink_shown);
        fetch_pair_t  src;
        int           k;
        logic [15:0]  word;
        logic         bit_val;
        logic         fg;
        color_t       nib;
        hires_pixel_t res;
        if (!visible) begin
            res.color         = r.border_color;
            res.is_background = 1'b0;
            return res;
        end
        // before the load point the tail of the previous pair is still shifting
        if (pix >= r.xscroll) begin
            src = cur;
            k   = pix - r.xscroll;
        end else begin
            src = prev;
            k   = pix + 8 - r.xscroll;
        end
        bit_val = src.pixel_byte[7 - k];
        word    = {src.color_byte, src.pixel_byte};
        res.color         = r.bg_color;
        res.is_background = 1'b1;
        case (r.mode)
            mode_text: begin
                fg = bit_val ^ (src.color_byte[attr_reverse_bit] | src.cursor);
                if (src.color_byte[attr_underline_bit] && row == 7) begin
                    fg = 1'b1;
                end
                if (src.color_byte[attr_blink_bit] && !blink_shown) begin
                    fg = 1'b0;
                end
                res.color         = fg ? src.color_byte[3:0] : r.bg_color;
                res.is_background = !bit_val;
            end
            mode_cell_bitmap: begin
                res.color         = bit_val ? src.color_byte[3:0] : r.bg_color;
                res.is_background = !bit_val;
            end
            mode_packed16, mode_wide16: begin
                // one nibble per 2 pixels, or per 4 pixels in the wide mode
                if (r.mode == mode_packed16) begin
                    nib = word[15 - 4 * (k / 2) -: 4];
                end else begin
                    nib = src.pixel_byte[7 - 4 * (k / 4) -: 4];
                end
                res.color         = nib;
                res.is_background = (nib == r.bg_color);
            end
            mode_packed4: begin
                res.color         = {r.color_base, word[15 - 2 * k -: 2]};
                res.is_background = (res.color == r.bg_color);
            end
            default: begin
                res.color = r.bg_color;
            end
        endcase
        return res;
    endfunction

    task automatic evaluate_pixel();
        bit           visible;
        hires_pixel_t want;
        visible = (pos_slot >= VIS_FIRST) && (pos_slot <= VIS_LAST) && (pos_line < VIS_LINES);
        // slot start, the queued pair moves into the shifter for this slot
        if (pos_pix == 0) begin
            prev_pair = cur_pair;
            cur_pair  = visible ? sent_pair : fetch_pair_t'('0);
            sent_pair = '0;
        end
        want = expect_pixel(regs, cur_pair, prev_pair, pos_pix, visible, pos_line % 8,
                            frame_cnt[blink_bit]);
        compare_flag("line_start", line_start, (pos_pix == 0 && pos_slot == 0 && pos_line == 0));
        compare_color("pixel.color", pixel.color, want.color);
        compare_flag("pixel.is_background", pixel.is_background, want.is_background);
        // slot after a skipped fetch must show plain background
        if (skip_odd_fetch && visible && pos_slot % 2 == 0 && pos_pix >= regs.xscroll) begin
            compare_color("pixel.color", pixel.color, regs.bg_color);
        end
        if (pos_pix == 3 && !(skip_odd_fetch && pos_slot % 2 == 1)) begin
            send_fetch(pos_slot);
        end
        pos_pix++;
        if (pos_pix == 8) begin
            pos_pix = 0;
            pos_slot++;
        end
        if (pos_slot == SLOTS) begin
            pos_slot = 0;
            pos_line++;
        end
        if (pos_line == LINES) begin
            pos_line = 0;
            frame_cnt++;
        end
    endtask

    task automatic run_frames(input int n);
        repeat (n * FRAME_PIXELS) begin
            wait_pixel();
            evaluate_pixel();
        end
    endtask

    task automatic reset_state();
        int n;
        n = 0;
        next_cycle();
        while (!rst_seen) begin
            compare_flag("pixel_valid", pixel_valid, 1'b0);
            compare_flag("line_start", line_start, 1'b0);
            n++;
            if (n > 16) begin
                abort_run("timeout, reset was never released");
            end
            next_cycle();
        end
        n = 0;
        while (line_start !== 1'b1) begin
            n++;
            if (n > 8) begin
                abort_run("timeout, no line_start within 8 clocks after reset");
            end
            next_cycle();
        end
        // model now sits on pixel 0 of slot 0, line 0, frame 0
        pos_pix   = 0;
        pos_slot  = 0;
        pos_line  = 0;
        frame_cnt = 0;
        evaluate_pixel();
    endtask

    task automatic border_pixels();
        set_regs(mode_cell_bitmap, 3'd0, 4'h1, 4'hb, 2'd0);
        pair_kind = 0;
        run_frames(1);
    endtask

    // runs until the blink bit has been both low and high
    task automatic text_attributes();
        set_regs(mode_text, 3'd0, 4'h0, 4'he, 2'd0);
        pair_kind = 1;
        while (frame_cnt <= (1 << blink_bit)) begin
            run_frames(1);
        end
    endtask

    task automatic bitmap_modes();
        pair_kind = 0;
        set_regs(mode_cell_bitmap, 3'd0, 4'h6, 4'h2, 2'd0);
        run_frames(1);
        set_regs(mode_packed16, 3'd0, 4'h3, 4'h5, 2'd0);
        run_frames(1);
        // base 2 maps the pixels to colours 8 to 11
        set_regs(mode_packed4, 3'd0, 4'h9, 4'h4, 2'd2);
        run_frames(1);
        set_regs(mode_wide16, 3'd0, 4'hc, 4'h7, 2'd0);
        run_frames(1);
    endtask

    task automatic fine_scroll();
        set_regs(mode_text, 3'd3, 4'h8, 4'hd, 2'd0);
        pair_kind = 1;
        run_frames(1);
    endtask

    task automatic missing_fetch();
        set_regs(mode_cell_bitmap, 3'd0, 4'ha, 4'h3, 2'd0);
        pair_kind      = 0;
        skip_odd_fetch = 1'b1;
        run_frames(1);
        skip_odd_fetch = 1'b0;
    endtask

    initial begin
        regs           = '0;
        regs.mode      = mode_text;
        fetch_strobe   = 1'b0;
        fetch_pair     = '0;
        cur_pair       = '0;
        prev_pair      = '0;
        sent_pair      = '0;
        pair_kind      = 0;
        skip_odd_fetch = 1'b0;
        rst_seen       = 1'b0;
        reset_state();
        border_pixels();
        text_attributes();
        bitmap_modes();
        fine_scroll();
        missing_fetch();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* tb.f */
logic/video_timing_pkg.sv
logic/hires_mode_pkg.sv
logic/dot_timing_gen.sv
logic/hires_fetch_queue.sv
logic/hires_pixel_sequencer.sv
logic/hires_video_top.sv
verification/dot_clock_gen.sv
verification/hires_video_tb.sv
